//--- ex_pkg.sv
package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // --------------------------------------------------
  // major opcodes
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type and M-type
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // --------------------------------------------------
  // funct3 codes
  // --------------------------------------------------
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101; // SRL and SRA
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [2:0] F3_MUL     = 3'b000;
  localparam logic [2:0] F3_MULH    = 3'b001;
  localparam logic [2:0] F3_MULHSU  = 3'b010;
  localparam logic [2:0] F3_MULHU   = 3'b011;

  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_BLTU    = 3'b110;
  localparam logic [2:0] F3_BGEU    = 3'b111;

  // --------------------------------------------------
  // funct7 codes
  // --------------------------------------------------
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB, SRA, SRAI
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // upper bits read either as funct7/rs2 or as a 12-bit immediate
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;    // also shamt of the immediate shifts
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i_fmt;
  } inst_u;

endpackage

//--- ex_operand_if.sv
`timescale 1ns/1ps

interface ex_operand_if;
  import ex_pkg::*;

  word_t op1;      // first operand
  word_t op2;      // second operand, immediate for OP-IMM
  word_t op1_jump; // jump base
  word_t op2_jump; // jump offset
  inst_u inst;
  logic  reg_we;   // decoder write request
  logic  valid;

  modport src (
    output op1, op2, op1_jump, op2_jump, inst, reg_we, valid
  );

  modport int_sink (
    input op1, op2, inst, reg_we
  );

  modport br_sink (
    input op1, op2, op1_jump, op2_jump, inst
  );

endinterface

//--- ex_mul.sv
`timescale 1ns/1ps

module ex_mul (
  input  ex_pkg::word_t a_i,
  input  ex_pkg::word_t b_i,
  input  logic [2:0]    funct3_i,
  output ex_pkg::word_t product_o
);
  import ex_pkg::*;

  logic        a_signed;  // a_i read as two's complement
  logic        b_signed;
  logic        negate;
  word_t       a_mag;
  word_t       b_mag;
  logic [63:0] prod_mag;
  logic [63:0] prod;

  always_comb
  begin
    case (funct3_i)
      F3_MULH:
      begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      F3_MULHSU:
      begin
        a_signed = 1'b1; // rs1 signed, rs2 unsigned
        b_signed = 1'b0;
      end
      default:
      begin
        a_signed = 1'b0; // MUL low word is sign agnostic
        b_signed = 1'b0;
      end
    endcase
  end

  assign a_mag  = (a_signed && a_i[31]) ? (~a_i + 32'd1) : a_i;
  assign b_mag  = (b_signed && b_i[31]) ? (~b_i + 32'd1) : b_i;
  assign negate = (a_signed & a_i[31]) ^ (b_signed & b_i[31]);

  assign prod_mag  = {32'd0, a_mag} * {32'd0, b_mag};
  assign prod      = negate ? (~prod_mag + 64'd1) : prod_mag; // restore sign
  assign product_o = (funct3_i == F3_MUL) ? prod[31:0] : prod[63:32];

  // divide codes are filtered out by the integer unit before they get here
  always_comb
  begin
    assert final (funct3_i[2] !== 1'b1)
      else $error("ex_mul: divide funct3 %b routed to the multiplier", funct3_i);
  end

endmodule

//--- ex_int_unit.sv
`timescale 1ns/1ps

module ex_int_unit (
  ex_operand_if.int_sink ops,
  output logic           int_hit_o,
  output logic           int_we_o,
  output ex_pkg::word_t  int_data_o
);
  import ex_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] sh_amt;
  logic       alt;       // funct7 selects SUB or SRA
  logic       mul_code;
  logic       mul_sel;
  logic [2:0] mul_f3;
  word_t      sum;
  word_t      diff;
  word_t      sra_res;
  word_t      base_res;
  word_t      mul_res;

  assign opcode = ops.inst.r_fmt.opcode;
  assign funct3 = ops.inst.r_fmt.funct3;
  assign funct7 = ops.inst.r_fmt.funct7;
  assign alt    = (funct7 == F7_ALT);

  // immediate shifts take shamt from the rs2 slot
  assign sh_amt  = (opcode == OPC_OP_IMM) ? ops.inst.r_fmt.rs2 : ops.op2[4:0];
  assign sum     = ops.op1 + ops.op2;
  assign diff    = ops.op1 - ops.op2;
  assign sra_res = word_t'($signed(ops.op1) >>> sh_amt);

  // --------------------------------------------------
  // multiplier, only fed a live code for real M ops
  // --------------------------------------------------
  assign mul_code = funct3 inside {F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU};
  assign mul_sel  = (opcode == OPC_OP) && (funct7 == F7_MULDIV) && mul_code;
  assign mul_f3   = mul_sel ? funct3 : F3_MUL;

  ex_mul u_mul (
    .a_i       (ops.op1),
    .b_i       (ops.op2),
    .funct3_i  (mul_f3),
    .product_o (mul_res)
  );

  // op2 already carries the immediate for OP-IMM
  always_comb
  begin
    case (funct3)
      F3_ADD_SUB: base_res = (alt && opcode == OPC_OP) ? diff : sum; // ADDI never subtracts
      F3_SLL:     base_res = ops.op1 << sh_amt;
      F3_SLT:     base_res = {31'd0, $signed(ops.op1) < $signed(ops.op2)};
      F3_SLTU:    base_res = {31'd0, ops.op1 < ops.op2};
      F3_XOR:     base_res = ops.op1 ^ ops.op2;
      F3_SR:      base_res = alt ? sra_res : (ops.op1 >> sh_amt);
      F3_OR:      base_res = ops.op1 | ops.op2;
      default:    base_res = ops.op1 & ops.op2; // F3_AND
    endcase
  end

  // --------------------------------------------------
  // legality decode
  // --------------------------------------------------
  always_comb
  begin
    int_hit_o  = 1'b0;
    int_data_o = base_res;
    case (opcode)
      OPC_OP_IMM:
      begin
        if (funct3 == F3_SLL)
          int_hit_o = (ops.inst.i_fmt.imm12[11:5] == F7_BASE);
        else if (funct3 == F3_SR)
          int_hit_o = (funct7 == F7_BASE) || alt;
        else
          int_hit_o = 1'b1;
      end
      OPC_OP:
      begin
        if (funct7 == F7_MULDIV)
        begin
          int_hit_o  = mul_code;
          int_data_o = mul_res;
        end
        else if (funct7 == F7_BASE)
          int_hit_o = 1'b1;
        else if (alt)
          int_hit_o = (funct3 == F3_ADD_SUB) || (funct3 == F3_SR);
      end
      OPC_LUI:
      begin
        int_hit_o  = 1'b1;
        int_data_o = ops.op1; // upper immediate prepared by decode
      end
      OPC_AUIPC:
      begin
        int_hit_o  = 1'b1;
        int_data_o = sum;     // pc + upper immediate
      end
      default:
      begin
        int_hit_o = 1'b0;
      end
    endcase
  end

  assign int_we_o = int_hit_o & ops.reg_we;

endmodule

//--- ex_branch_unit.sv
`timescale 1ns/1ps

module ex_branch_unit (
  ex_operand_if.br_sink ops,
  output logic          br_hit_o,
  output logic          link_we_o,
  output ex_pkg::word_t link_data_o,
  output logic          jump_flag_o,
  output ex_pkg::word_t jump_addr_o
);
  import ex_pkg::*;

  word_t target;
  logic  eq;
  logic  lt;  // signed
  logic  ltu;

  assign target = word_t'($signed(ops.op1_jump) + $signed(ops.op2_jump));
  assign eq     = (ops.op1 == ops.op2);
  assign lt     = ($signed(ops.op1) < $signed(ops.op2));
  assign ltu    = (ops.op1 < ops.op2);

  always_comb
  begin
    br_hit_o    = 1'b0;
    link_we_o   = 1'b0;
    link_data_o = '0;
    jump_flag_o = 1'b0;
    jump_addr_o = '0;
    case (ops.inst.r_fmt.opcode)
      OPC_BRANCH:
      begin
        br_hit_o    = 1'b1;
        jump_addr_o = target; // target given even when not taken
        case (ops.inst.r_fmt.funct3)
          F3_BEQ:  jump_flag_o = eq;
          F3_BNE:  jump_flag_o = ~eq;
          F3_BLT:  jump_flag_o = lt;
          F3_BGE:  jump_flag_o = ~lt;
          F3_BLTU: jump_flag_o = ltu;
          F3_BGEU: jump_flag_o = ~ltu;
          default:
          begin
            br_hit_o    = 1'b0; // 010 and 011 are reserved
            jump_addr_o = '0;
          end
        endcase
      end
      OPC_JAL, OPC_JALR:
      begin
        br_hit_o    = 1'b1;
        link_we_o   = 1'b1;
        link_data_o = ops.op1 + ops.op2; // return address
        jump_flag_o = 1'b1;
        jump_addr_o = target;
      end
      default:
      begin
        br_hit_o = 1'b0;
      end
    endcase
  end

endmodule

//--- ex_commit.sv
`timescale 1ns/1ps

module ex_commit (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  ex_pkg::reg_addr_t rd_i,
  input  logic              int_hit_i,
  input  logic              int_we_i,
  input  ex_pkg::word_t     int_data_i,
  input  logic              br_hit_i,
  input  logic              link_we_i,
  input  ex_pkg::word_t     link_data_i,
  input  logic              jump_flag_i,
  input  ex_pkg::word_t     jump_addr_i,
  output logic              rd_we_o,
  output ex_pkg::reg_addr_t rd_waddr_o,
  output ex_pkg::word_t     rd_data_o,
  output logic              jump_flag_o,
  output ex_pkg::word_t     jump_addr_o
);
  import ex_pkg::*;

  logic      take_int;
  logic      take_br;
  logic      rd_we_d;
  reg_addr_t rd_waddr_d;
  word_t     rd_data_d;
  logic      jump_flag_d;
  word_t     jump_addr_d;

  assign take_int = valid_i & int_hit_i;
  assign take_br  = valid_i & br_hit_i;

  // --------------------------------------------------
  // source select, nothing claimed gives all zero
  // --------------------------------------------------
  always_comb
  begin
    rd_we_d     = 1'b0;
    rd_waddr_d  = '0;
    rd_data_d   = '0;
    jump_flag_d = 1'b0;
    jump_addr_d = '0;
    if (take_int)
    begin
      rd_we_d    = int_we_i;
      rd_waddr_d = rd_i;
      rd_data_d  = int_data_i;
    end
    else if (take_br)
    begin
      rd_we_d     = link_we_i;
      rd_waddr_d  = rd_i;
      rd_data_d   = link_data_i;
      jump_flag_d = jump_flag_i;
      jump_addr_d = jump_addr_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      rd_we_o     <= 1'b0;
      rd_waddr_o  <= '0;
      rd_data_o   <= '0;
      jump_flag_o <= 1'b0;
      jump_addr_o <= '0;
    end
    else
    begin
      rd_we_o     <= rd_we_d;
      rd_waddr_o  <= rd_waddr_d;
      rd_data_o   <= rd_data_d;
      jump_flag_o <= jump_flag_d;
      jump_addr_o <= jump_addr_d;
    end
  end

  // the two unit decoders must stay disjoint
  a_one_hit: assert property (@(posedge clk) disable iff (rst_i)
    valid_i |-> !(int_hit_i && br_hit_i));

endmodule

//--- ex_top.sv
`timescale 1ns/1ps

module ex_top (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  ex_pkg::word_t     inst_i,
  input  ex_pkg::word_t     op1_i,
  input  ex_pkg::word_t     op2_i,
  input  ex_pkg::word_t     op1_jump_i,
  input  ex_pkg::word_t     op2_jump_i,
  input  logic              reg_we_i,
  output logic              rd_we_o,
  output ex_pkg::reg_addr_t rd_waddr_o,
  output ex_pkg::word_t     rd_data_o,
  output logic              jump_flag_o,
  output ex_pkg::word_t     jump_addr_o
);
  import ex_pkg::*;

  logic  int_hit;
  logic  int_we;
  word_t int_data;
  logic  br_hit;
  logic  link_we;
  word_t link_data;
  logic  jump_flag;
  word_t jump_addr;

  // --------------------------------------------------
  // operand bundle shared by both units
  // --------------------------------------------------
  ex_operand_if ops ();

  assign ops.op1      = op1_i;
  assign ops.op2      = op2_i;
  assign ops.op1_jump = op1_jump_i;
  assign ops.op2_jump = op2_jump_i;
  assign ops.inst     = inst_i;
  assign ops.reg_we   = reg_we_i;
  assign ops.valid    = valid_i;

  ex_int_unit u_int (
    .ops        (ops.int_sink),
    .int_hit_o  (int_hit),
    .int_we_o   (int_we),
    .int_data_o (int_data)
  );

  ex_branch_unit u_br (
    .ops         (ops.br_sink),
    .br_hit_o    (br_hit),
    .link_we_o   (link_we),
    .link_data_o (link_data),
    .jump_flag_o (jump_flag),
    .jump_addr_o (jump_addr)
  );

  ex_commit u_commit (
    .clk         (clk),
    .rst_i       (rst_i),
    .valid_i     (ops.valid),
    .rd_i        (ops.inst.r_fmt.rd), // destination always from the rd field
    .int_hit_i   (int_hit),
    .int_we_i    (int_we),
    .int_data_i  (int_data),
    .br_hit_i    (br_hit),
    .link_we_i   (link_we),
    .link_data_i (link_data),
    .jump_flag_i (jump_flag),
    .jump_addr_i (jump_addr),
    .rd_we_o     (rd_we_o),
    .rd_waddr_o  (rd_waddr_o),
    .rd_data_o   (rd_data_o),
    .jump_flag_o (jump_flag_o),
    .jump_addr_o (jump_addr_o)
  );

endmodule

//--- tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;
  import ex_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 5;
  localparam int          MAX_VEC      = 256;
  localparam logic [31:0] LFSR_SEED    = 32'h8b4f_ea7e;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003; // x^32+x^22+x^2+x+1
  localparam string       TRACE_FILE   = "ex_trace.txt";

  // --------------------------------------------------
  // trace columns
  // --------------------------------------------------
  localparam int COL_INST      = 0;
  localparam int COL_OP1       = 1;
  localparam int COL_OP2       = 2;
  localparam int COL_OP1_JUMP  = 3;
  localparam int COL_OP2_JUMP  = 4;
  localparam int COL_REG_WE    = 5;
  localparam int COL_RD_WE     = 6;
  localparam int COL_RD_WADDR  = 7;
  localparam int COL_RD_DATA   = 8;
  localparam int COL_JUMP_FLAG = 9;
  localparam int COL_JUMP_ADDR = 10;
  localparam int NUM_COLS      = 11;

  logic      clk;
  logic      rst_i;
  logic      valid_i;
  word_t     inst_i;
  word_t     op1_i;
  word_t     op2_i;
  word_t     op1_jump_i;
  word_t     op2_jump_i;
  logic      reg_we_i;
  logic      rd_we_o;
  reg_addr_t rd_waddr_o;
  word_t     rd_data_o;
  logic      jump_flag_o;
  word_t     jump_addr_o;

  word_t       trace_mem [0:MAX_VEC-1][0:NUM_COLS-1];
  int          num_vec;
  logic        trace_loaded;
  logic [31:0] lfsr_state;

  ex_top ex_top_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .inst_i      (inst_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .op1_jump_i  (op1_jump_i),
    .op2_jump_i  (op2_jump_i),
    .reg_we_i    (reg_we_i),
    .rd_we_o     (rd_we_o),
    .rd_waddr_o  (rd_waddr_o),
    .rd_data_o   (rd_data_o),
    .jump_flag_o (jump_flag_o),
    .jump_addr_o (jump_addr_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois form, shifts right
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = {1'b0, state[31:1]} ^ (state[0] ? LFSR_TAPS : 32'h0);
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t expected);
    if (got !== expected)
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic load_trace();
    integer fd;
    integer rc;
    string  line;
    word_t  col [0:NUM_COLS-1];
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the trace file %s", TRACE_FILE);
      $display("SIMULATION FAILED");
      $fatal(1, "no stimulus");
    end
    num_vec = 0;
    while (!$feof(fd))
    begin
      line = "";
      rc = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == "#")
        continue; // blank or column notes
      rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                   col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10]);
      if (rc != NUM_COLS || num_vec >= MAX_VEC)
      begin
        $display("trace line %0d is malformed or the trace is too long", num_vec);
        $display("SIMULATION FAILED");
        $fatal(1, "bad trace");
      end
      for (int c = 0; c < NUM_COLS; c++)
        trace_mem[num_vec][c] = col[c];
      num_vec++;
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input int idx);
    valid_i    = 1'b1;
    inst_i     = trace_mem[idx][COL_INST];
    op1_i      = trace_mem[idx][COL_OP1];
    op2_i      = trace_mem[idx][COL_OP2];
    op1_jump_i = trace_mem[idx][COL_OP1_JUMP];
    op2_jump_i = trace_mem[idx][COL_OP2_JUMP];
    reg_we_i   = trace_mem[idx][COL_REG_WE][0];
  endtask

  task automatic check_vector(input int idx);
    check_value("rd_we_o", rd_we_o, trace_mem[idx][COL_RD_WE]);
    check_value("rd_waddr_o", rd_waddr_o, trace_mem[idx][COL_RD_WADDR]);
    check_value("rd_data_o", rd_data_o, trace_mem[idx][COL_RD_DATA]);
    check_value("jump_flag_o", jump_flag_o, trace_mem[idx][COL_JUMP_FLAG]);
    check_value("jump_addr_o", jump_addr_o, trace_mem[idx][COL_JUMP_ADDR]);
  endtask

  task automatic check_idle_outputs();
    check_value("rd_we_o", rd_we_o, '0);
    check_value("jump_flag_o", jump_flag_o, '0);
  endtask

  task automatic check_reset_outputs();
    check_idle_outputs();
    check_value("rd_waddr_o", rd_waddr_o, '0);
    check_value("rd_data_o", rd_data_o, '0);
    check_value("jump_addr_o", jump_addr_o, '0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    rst_i        = 1'b1;
    valid_i      = 1'b0;
    inst_i       = '0;
    op1_i        = '0;
    op2_i        = '0;
    op1_jump_i   = '0;
    op2_jump_i   = '0;
    reg_we_i     = 1'b0;
    trace_loaded = 1'b0;
    lfsr_state   = LFSR_SEED;
    load_trace();
    trace_loaded = 1'b1;

    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst_i = 1'b0;
    @(negedge clk);
    check_reset_outputs(); // nothing issued yet

    for (int i = 0; i < num_vec; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      if (lfsr_state[0])
      begin
        valid_i = 1'b0; // old operands stay on the bus
        @(negedge clk);
        check_idle_outputs();
      end
      apply_vector(i);
      @(negedge clk);
      check_vector(i);
    end

    valid_i = 1'b0;
    @(negedge clk);
    check_idle_outputs();
    $display("SIMULATION PASSED");
    $finish;
  end

  // each vector needs at most two cycles
  initial
  begin
    wait (trace_loaded);
    #((num_vec * 2 + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", num_vec * 2 + 20);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- ex_trace.txt
# inputs:   inst op1 op2 op1_jump op2_jump reg_we
# expected: rd_we rd_waddr rd_data jump_flag jump_addr  (all hex)
002081B3 FFFFFFFF 00000002 00000000 00000000 1 1 03 00000001 0 00000000
40208233 00000000 00000001 00000000 00000000 1 1 04 FFFFFFFF 0 00000000
0020A2B3 FFFFFFFF 00000001 00000000 00000000 1 1 05 00000001 0 00000000
0020B333 FFFFFFFF 00000001 00000000 00000000 1 1 06 00000000 0 00000000
0020C3B3 F0F0F0F0 0FF00FF0 00000000 00000000 1 1 07 FF00FF00 0 00000000
0020E433 F0F0F0F0 0FF00FF0 00000000 00000000 1 1 08 FFF0FFF0 0 00000000
0020F4B3 F0F0F0F0 0FF00FF0 00000000 00000000 1 1 09 00F000F0 0 00000000
00209533 80000001 00000024 00000000 00000000 1 1 0A 00000010 0 00000000
0020D5B3 80000000 00000004 00000000 00000000 1 1 0B 08000000 0 00000000
4020D633 80000000 00000004 00000000 00000000 1 1 0C F8000000 0 00000000
FFF08693 00000005 FFFFFFFF 00000000 00000000 1 1 0D 00000004 0 00000000
4080D713 80001234 00000408 00000000 00000000 1 1 0E FF800012 0 00000000
0080D793 80001234 00000008 00000000 00000000 1 1 0F 00800012 0 00000000
020088B3 FFFFFFFE 00000003 00000000 00000000 1 1 11 FFFFFFFA 0 00000000
02209933 FFFFFFFE 00000003 00000000 00000000 1 1 12 FFFFFFFF 0 00000000
022099B3 80000000 80000000 00000000 00000000 1 1 13 40000000 0 00000000
02209A33 7FFFFFFF 7FFFFFFF 00000000 00000000 1 1 14 3FFFFFFF 0 00000000
02209AB3 00000002 FFFFFFFF 00000000 00000000 1 1 15 FFFFFFFF 0 00000000
0220AB33 FFFFFFFF FFFFFFFF 00000000 00000000 1 1 16 FFFFFFFF 0 00000000
0220ABB3 00000002 80000000 00000000 00000000 1 1 17 00000001 0 00000000
0220BC33 FFFFFFFF FFFFFFFF 00000000 00000000 1 1 18 FFFFFFFE 0 00000000
00208463 00000005 00000005 00001000 00000008 0 0 08 00000000 1 00001008
00209463 00000005 00000005 00001000 FFFFFFF0 0 0 08 00000000 0 00000FF0
0020C463 FFFFFFFF 00000001 00002000 00000010 0 0 08 00000000 1 00002010
0020D463 FFFFFFFF 00000001 00003000 FFFFFFFC 0 0 08 00000000 0 00002FFC
0020E463 FFFFFFFF 00000001 00004000 00000004 0 0 08 00000000 0 00004004
0020F463 FFFFFFFF 00000001 00005000 00000100 0 0 08 00000000 1 00005100
008000EF 00001000 00000004 00001000 00000008 1 1 01 00001004 1 00001008
010082E7 00002000 00000004 00003000 00000010 1 1 05 00002004 1 00003010
12345337 12345000 00000000 00000000 00000000 1 1 06 12345000 0 00000000
00001397 00000400 00001000 00000000 00000000 1 1 07 00001400 0 00000000
202081B3 00000001 00000002 00000000 00000000 1 0 00 00000000 0 00000000
002081B3 00000001 00000002 00000000 00000000 0 0 03 00000003 0 00000000

//--- tb.f
ex_pkg.sv
ex_operand_if.sv
ex_mul.sv
ex_int_unit.sv
ex_branch_unit.sv
ex_commit.sv
ex_top.sv
tb_ex_top.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - ex_pkg.sv
      - ex_operand_if.sv
      - ex_mul.sv
      - ex_int_unit.sv
      - ex_branch_unit.sv
      - ex_commit.sv
      - ex_top.sv
  - target: test
    files:
      - tb_ex_top.sv
